//--- common/csr_pkg.sv
// shared CSR addresses, field constants, operation codes and bus structs for the CSR block
package csr_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int CAUSE_W    = 6;  // msb flags an interrupt
  localparam int N_PERF_CNT = 8;

  // access operation from the core
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////
  // addresses
  ////////////////////
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DCSR      = 12'h7B0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DPC       = 12'h7B1;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DSCRATCH0 = 12'h7B2;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DSCRATCH1 = 12'h7B3;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_BASE = 12'h780; // counters, 0x780..0x79E
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_ALL  = 12'h79F; // write hits every counter
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCER      = 12'h7A0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCMR      = 12'h7A1;

  // mstatus fields
  localparam int         MSTATUS_MIE_BIT  = 3;
  localparam int         MSTATUS_MPIE_BIT = 7;
  localparam int         MSTATUS_MPP_LSB  = 11;
  localparam logic [1:0] MSTATUS_MPP      = 2'b11; // always machine

  localparam logic [1:0] MTVEC_MODE     = 2'b01; // vectored
  localparam logic [3:0] DCSR_XDEBUGVER = 4'h4;  // external debug present
  localparam logic [1:0] PCMR_RESET     = 2'b11; // enabled, saturating

  ////////////////////
  // structs
  ////////////////////
  typedef struct packed {
    logic                  access;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
    csr_op_e               op;
  } csr_req_t;

  // controller side of trap handling
  typedef struct packed {
    logic               save_cause;
    logic               save_if;
    logic               save_id;
    logic [CAUSE_W-1:0] cause;
    logic               mret;
    logic               dret;
  } trap_ctrl_t;

  typedef struct packed {
    logic id_valid;     // decode stage done
    logic is_decoding;  // controller in decode
    logic ld_stall;     // load-use hazard
    logic jr_stall;     // jump register hazard
    logic imiss;        // waiting on fetch
    logic pc_set;       // fetch redirected
    logic mem_load;
    logic mem_store;
    logic branch;
    logic branch_taken;
    logic is_compressed;
  } perf_evt_in_t;

  typedef struct packed {
    logic [XLEN-1:0] pc_if;
    logic [XLEN-1:0] pc_id;
  } pc_set_t;

endpackage

//--- perf/perf_event_map.sv
// maps pipeline status into the eight performance counter events
`timescale 1ns/1ps

module perf_event_map (
  input  logic                           clk,
  input  logic                           rst_n,
  input  csr_pkg::perf_evt_in_t          perf_evt_i,
  output logic [csr_pkg::N_PERF_CNT-1:0] events_o
);

  logic id_valid_q;

  // stall and branch flags belong to the instruction that left decode last cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= perf_evt_i.id_valid;
    end
  end

  ////////////////////
  // event sources
  ////////////////////
  assign events_o[0] = 1'b1;                                         // cycles
  assign events_o[1] = perf_evt_i.id_valid & perf_evt_i.is_decoding; // instructions
  assign events_o[2] = perf_evt_i.ld_stall & id_valid_q;             // load-use hazards
  assign events_o[3] = perf_evt_i.jr_stall & id_valid_q;             // jr hazards
  assign events_o[4] = perf_evt_i.imiss & ~perf_evt_i.pc_set;        // fetch wait, no redirect
  assign events_o[5] = perf_evt_i.mem_load;
  assign events_o[6] = perf_evt_i.mem_store;

  // conditional branches that were taken
  assign events_o[7] = perf_evt_i.branch & perf_evt_i.branch_taken & id_valid_q;

endmodule

//--- perf/perf_counter_bank.sv
// performance counters with event enable and mode registers, read and written as CSRs
`timescale 1ns/1ps

module perf_counter_bank (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [csr_pkg::N_PERF_CNT-1:0] events_i,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]       perf_rdata_o,
  output logic                           perf_hit_o
);

  import csr_pkg::*;

  localparam int IDX_W = $clog2(N_PERF_CNT);

  logic [N_PERF_CNT-1:0][XLEN-1:0] cnt_q, cnt_n;
  logic [N_PERF_CNT-1:0]           pcer_q, pcer_n;  // per-event enable
  logic [1:0]                      pcmr_q, pcmr_n;  // bit 0 enable, bit 1 saturate
  logic [N_PERF_CNT-1:0]           inc, inc_q;
  logic                            is_pccr;
  logic                            is_pccr_all;
  logic                            is_pcer;
  logic                            is_pcmr;
  logic [4:0]                      pccr_idx;

  ////////////////////
  // address decode
  ////////////////////
  assign is_pccr     = (csr_addr_i[11:5] == ADDR_PCCR_BASE[11:5]); // whole 0x780 window
  assign is_pccr_all = (csr_addr_i == ADDR_PCCR_ALL);
  assign is_pcer     = (csr_addr_i == ADDR_PCER);
  assign is_pcmr     = (csr_addr_i == ADDR_PCMR);
  assign pccr_idx    = csr_addr_i[4:0];
  assign perf_hit_o  = is_pccr | is_pcer | is_pcmr;

  always_comb begin
    perf_rdata_o = '0;
    if (is_pccr) begin
      // unused slots and the broadcast address read as zero
      if (!is_pccr_all && (pccr_idx < N_PERF_CNT)) begin
        perf_rdata_o = cnt_q[pccr_idx[IDX_W-1:0]];
      end
    end else if (is_pcer) begin
      perf_rdata_o[N_PERF_CNT-1:0] = pcer_q;
    end else if (is_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end
  end

  // increment requests, applied one cycle later
  assign inc = events_i & pcer_q & {N_PERF_CNT{pcmr_q[0]}};

  ////////////////////
  // counter update
  ////////////////////
  always_comb begin
    for (int i = 0; i < N_PERF_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
        cnt_n[i] = cnt_q[i] + 1'b1;
      end
      // software write beats the increment
      if (csr_we_i && is_pccr && (is_pccr_all || (pccr_idx == i))) begin
        cnt_n[i] = csr_wdata_i;
      end
    end
  end

  always_comb begin
    pcer_n = pcer_q;
    pcmr_n = pcmr_q;
    if (csr_we_i && is_pcer) pcer_n = csr_wdata_i[N_PERF_CNT-1:0];
    if (csr_we_i && is_pcmr) pcmr_n = csr_wdata_i[1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      inc_q  <= '0;
      pcer_q <= '0;
      pcmr_q <= PCMR_RESET;
    end else begin
      cnt_q  <= cnt_n;
      inc_q  <= inc;
      pcer_q <= pcer_n;
      pcmr_q <= pcmr_n;
    end
  end

endmodule

//--- trap/csr_trap_regs.sv
// machine trap and debug CSRs, updated by CSR writes and by trap entry, mret and dret pulses
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  input  csr_pkg::trap_ctrl_t            trap_ctrl_i,
  input  csr_pkg::pc_set_t               pc_i,
  input  logic [3:0]                     core_id_i,
  input  logic [5:0]                     cluster_id_i,
  input  logic [30:0]                    boot_addr_i,
  output logic [csr_pkg::XLEN-1:0]       trap_rdata_o,
  output logic                           mie_o,
  output logic [23:0]                    mtvec_o,
  output logic [csr_pkg::XLEN-1:0]       mepc_o,
  output logic [csr_pkg::XLEN-1:0]       depc_o
);

  import csr_pkg::*;

  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  mstatus_t           mstatus_q, mstatus_n;
  logic [XLEN-1:0]    mepc_q, mepc_n;
  logic [CAUSE_W-1:0] mcause_q, mcause_n;
  logic [XLEN-1:0]    dcsr_q, dcsr_n;
  logic [XLEN-1:0]    depc_q, depc_n;
  logic [XLEN-1:0]    dscratch0_q, dscratch0_n;
  logic [XLEN-1:0]    dscratch1_q, dscratch1_n;
  logic [XLEN-1:0]    boot_pc;
  logic [XLEN-1:0]    exception_pc;

  assign boot_pc = {boot_addr_i, 1'b0};
  assign mtvec_o = boot_pc[XLEN-1:8]; // trap base tied to boot, not writable

  ////////////////////
  // read decode
  ////////////////////
  always_comb begin
    trap_rdata_o = '0;
    case (csr_addr_i)
      ADDR_MSTATUS: begin
        trap_rdata_o[MSTATUS_MIE_BIT]                     = mstatus_q.mie;
        trap_rdata_o[MSTATUS_MPIE_BIT]                    = mstatus_q.mpie;
        trap_rdata_o[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB]   = MSTATUS_MPP;
      end
      ADDR_MTVEC:     trap_rdata_o = {mtvec_o, 6'h0, MTVEC_MODE};
      ADDR_MEPC:      trap_rdata_o = mepc_q;
      ADDR_MCAUSE:    trap_rdata_o = {mcause_q[CAUSE_W-1], 26'b0, mcause_q[CAUSE_W-2:0]};
      ADDR_MHARTID:   trap_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      ADDR_DCSR:      trap_rdata_o = dcsr_q;
      ADDR_DPC:       trap_rdata_o = depc_q;
      ADDR_DSCRATCH0: trap_rdata_o = dscratch0_q;
      ADDR_DSCRATCH1: trap_rdata_o = dscratch1_q;
      default:        trap_rdata_o = '0;
    endcase
  end

  assign exception_pc = trap_ctrl_i.save_if ? pc_i.pc_if : pc_i.pc_id;

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    mstatus_n   = mstatus_q;
    mepc_n      = mepc_q;
    mcause_n    = mcause_q;
    dcsr_n      = dcsr_q;
    depc_n      = depc_q;
    dscratch0_n = dscratch0_q;
    dscratch1_n = dscratch1_q;

    if (csr_we_i) begin
      case (csr_addr_i)
        ADDR_MSTATUS: begin
          mstatus_n.mie  = csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_n.mpie = csr_wdata_i[MSTATUS_MPIE_BIT];
        end
        ADDR_MEPC:      mepc_n      = csr_wdata_i;
        ADDR_MCAUSE:    mcause_n    = {csr_wdata_i[XLEN-1], csr_wdata_i[CAUSE_W-2:0]};
        ADDR_DCSR:      dcsr_n      = {DCSR_XDEBUGVER, csr_wdata_i[27:2], MSTATUS_MPP};
        ADDR_DPC:       depc_n      = csr_wdata_i;
        ADDR_DSCRATCH0: dscratch0_n = csr_wdata_i;
        ADDR_DSCRATCH1: dscratch1_n = csr_wdata_i;
        default: ;
      endcase
    end

    // controller events override a CSR write in the same cycle
    if (trap_ctrl_i.save_cause) begin
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
      mepc_n         = exception_pc;
      depc_n         = exception_pc;
      mcause_n       = trap_ctrl_i.cause;
    end else if (trap_ctrl_i.mret || trap_ctrl_i.dret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q   <= '0;
      mepc_q      <= '0;
      mcause_q    <= '0;
      dcsr_q      <= {DCSR_XDEBUGVER, 26'b0, MSTATUS_MPP};
      depc_q      <= '0;
      dscratch0_q <= '0;
      dscratch1_q <= '0;
    end else begin
      mstatus_q   <= mstatus_n;
      mepc_q      <= mepc_n;
      mcause_q    <= mcause_n;
      dcsr_q      <= dcsr_n;
      depc_q      <= depc_n;
      dscratch0_q <= dscratch0_n;
      dscratch1_q <= dscratch1_n;
    end
  end

  assign mie_o  = mstatus_q.mie;  // privilege is always machine
  assign mepc_o = mepc_q;
  assign depc_o = depc_q;

endmodule

//--- verilog/csr_access_ctrl.sv
// read mux and write/set/clear merge between the core access port and the CSR blocks
`timescale 1ns/1ps

module csr_access_ctrl (
  input  csr_pkg::csr_req_t        csr_req_i,
  input  logic [csr_pkg::XLEN-1:0] trap_rdata_i,
  input  logic [csr_pkg::XLEN-1:0] perf_rdata_i,
  input  logic                     perf_hit_i,   // perf block owns the address
  output logic                     csr_we_o,
  output logic [csr_pkg::XLEN-1:0] csr_wdata_o,
  output logic [csr_pkg::XLEN-1:0] csr_rdata_o
);

  import csr_pkg::*;

  logic [XLEN-1:0] rdata_cur;

  ////////////////////
  // read side
  ////////////////////

  // each block decodes its own range, perf wins on a hit
  assign rdata_cur   = perf_hit_i ? perf_rdata_i : trap_rdata_i;
  assign csr_rdata_o = rdata_cur;

  ////////////////////
  // write side
  ////////////////////

  // op none is a pure read
  assign csr_we_o = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);

  // set and clear work on the value being read this cycle
  always_comb begin
    case (csr_req_i.op)
      CSR_OP_WRITE: begin
        csr_wdata_o = csr_req_i.wdata;
      end
      CSR_OP_SET: begin
        csr_wdata_o = rdata_cur | csr_req_i.wdata;
      end
      CSR_OP_CLEAR: begin
        csr_wdata_o = rdata_cur & ~csr_req_i.wdata;
      end
      default: begin
        csr_wdata_o = csr_req_i.wdata; // no strobe anyway
      end
    endcase
  end

endmodule

//--- verilog/csr_file_top.sv
// top of the machine-mode CSR file, connects access merge, trap registers and perf counters
`timescale 1ns/1ps

module csr_file_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // hart identity and boot vector
  input  logic [3:0]                 core_id_i,
  input  logic [5:0]                 cluster_id_i,
  input  logic [30:0]                boot_addr_i,

  // access port, single cycle
  input  csr_pkg::csr_req_t          csr_req_i,
  output logic [csr_pkg::XLEN-1:0]   csr_rdata_o,

  // controller side
  input  csr_pkg::trap_ctrl_t        trap_ctrl_i,
  input  csr_pkg::pc_set_t           pc_i,
  input  csr_pkg::perf_evt_in_t      perf_evt_i,

  output logic                       mie_o,
  output logic [23:0]                mtvec_o,
  output logic [csr_pkg::XLEN-1:0]   mepc_o,
  output logic [csr_pkg::XLEN-1:0]   depc_o
);

  import csr_pkg::*;

  logic                  csr_we;
  logic [XLEN-1:0]       csr_wdata;
  logic [XLEN-1:0]       trap_rdata;
  logic [XLEN-1:0]       perf_rdata;
  logic                  perf_hit;
  logic [N_PERF_CNT-1:0] events;

  csr_access_ctrl u_access_ctrl (
    .csr_req_i    (csr_req_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .csr_we_o     (csr_we),
    .csr_wdata_o  (csr_wdata),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs u_trap_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_we_i     (csr_we),
    .csr_addr_i   (csr_req_i.addr),
    .csr_wdata_i  (csr_wdata),
    .trap_ctrl_i  (trap_ctrl_i),
    .pc_i         (pc_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .trap_rdata_o (trap_rdata),
    .mie_o        (mie_o),
    .mtvec_o      (mtvec_o),
    .mepc_o       (mepc_o),
    .depc_o       (depc_o)
  );

  perf_event_map u_event_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .perf_evt_i (perf_evt_i),
    .events_o   (events)
  );

  perf_counter_bank u_counter_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .events_i     (events),
    .csr_we_i     (csr_we),
    .csr_addr_i   (csr_req_i.addr),
    .csr_wdata_i  (csr_wdata),
    .perf_rdata_o (perf_rdata),
    .perf_hit_o   (perf_hit)
  );

endmodule

//--- tb/csr_tb_tasks.svh
// access, pulse and check tasks plus the expected-value model, included inside the CSR testbench
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// expected register value after write, set or clear
function automatic logic [XLEN-1:0] merge_op(input csr_op_e op, input logic [XLEN-1:0] old_val,
                                             input logic [XLEN-1:0] wdata);
  case (op)
    CSR_OP_WRITE: merge_op = wdata;
    CSR_OP_SET:   merge_op = old_val | wdata;
    CSR_OP_CLEAR: merge_op = old_val & ~wdata;
    default:      merge_op = old_val;
  endcase
endfunction

task automatic check_equal(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
  checks++;
  assert (got === exp)
    else begin
      errors++;
      $display("ERR %s exp=%h got=%h", name, exp, got);
    end
endtask

////////////////////
// bus activity
////////////////////
task automatic access_csr(input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
                          input logic [XLEN-1:0] wdata);
  @(negedge clk);
  csr_req.access = 1'b1;
  csr_req.addr   = addr;
  csr_req.wdata  = wdata;
  csr_req.op     = op;
  @(negedge clk);
  csr_req.op = CSR_OP_NONE;  // committed at the edge in between
endtask

task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
  @(negedge clk);
  csr_req.access = 1'b1;
  csr_req.addr   = addr;
  csr_req.op     = CSR_OP_NONE;
  #(PERIOD / 4);  // combinational read, settled well before the next edge
  data = csr_rdata;
endtask

task automatic trap_pulse(input logic from_if, input logic [CAUSE_W-1:0] cause,
                          input logic with_write, input logic [XLEN-1:0] wr_data);
  @(negedge clk);
  trap_ctrl.save_cause = 1'b1;
  trap_ctrl.save_if    = from_if;
  trap_ctrl.save_id    = !from_if;
  trap_ctrl.cause      = cause;
  if (with_write) begin
    csr_req.access = 1'b1;
    csr_req.addr   = ADDR_MEPC;
    csr_req.wdata  = wr_data;
    csr_req.op     = CSR_OP_WRITE;
  end
  @(negedge clk);
  trap_ctrl  = '0;
  csr_req.op = CSR_OP_NONE;
endtask

task automatic ret_pulse(input logic is_dret);
  @(negedge clk);
  trap_ctrl.mret = !is_dret;
  trap_ctrl.dret = is_dret;
  @(negedge clk);
  trap_ctrl = '0;
endtask

task automatic drive_loads(input int n);
  repeat (n) begin
    @(negedge clk);
    perf_evt.mem_load = 1'b1;
  end
  @(negedge clk);
  perf_evt.mem_load = 1'b0;
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

`endif

//--- tb/csr_file_tb.sv
// testbench for the CSR file, drives access port, trap pulses and load events, checks responses
`timescale 1ns/1ps

module csr_file_tb;

  import csr_pkg::*;

  localparam int PERIOD     = 100;
  localparam int MAX_CYCLES = 400;  // sequence needs about 130 cycles

  localparam logic [30:0] BOOT_ADDR = 31'h0E00_4080;
  localparam logic [23:0] MTVEC_EXP = 24'h1C_0081;  // boot pc 0x1C008100 without its low byte

  logic            clk;
  logic            rst_n;
  logic [3:0]      core_id;
  logic [5:0]      cluster_id;
  logic [30:0]     boot_addr;
  csr_req_t        csr_req;
  trap_ctrl_t      trap_ctrl;
  pc_set_t         pc;
  perf_evt_in_t    perf_evt;
  logic [XLEN-1:0] csr_rdata;
  logic            mie;
  logic [23:0]     mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] depc;

  integer seed = 85;
  int     checks = 0;
  int     errors = 0;

  `include "csr_tb_tasks.svh"

  csr_file_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .boot_addr_i  (boot_addr),
    .csr_req_i    (csr_req),
    .csr_rdata_o  (csr_rdata),
    .trap_ctrl_i  (trap_ctrl),
    .pc_i         (pc),
    .perf_evt_i   (perf_evt),
    .mie_o        (mie),
    .mtvec_o      (mtvec),
    .mepc_o       (mepc),
    .depc_o       (depc)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // continuous checks
  ////////////////////
  mtvec_tracks_boot: assert property (@(posedge clk) disable iff (!rst_n)
    mtvec == MTVEC_EXP)
    else begin
      errors++;
      $display("ERR mtvec_o exp=%h got=%h", MTVEC_EXP, mtvec);
    end

  // interrupts off right after any trap entry
  trap_clears_mie: assert property (@(posedge clk) disable iff (!rst_n)
    trap_ctrl.save_cause |=> !mie)
    else begin
      errors++;
      $display("ERR mie_o exp=%h got=%h", 1'b0, mie);
    end

  initial begin
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] model_mepc;
    logic [XLEN-1:0] model_ds0;
    logic [XLEN-1:0] pc_a;
    int              n_loads;
    csr_op_e         op;

    rst_n      = 1'b0;
    core_id    = 4'h5;
    cluster_id = 6'h2A;
    boot_addr  = BOOT_ADDR;
    csr_req    = '0;
    trap_ctrl  = '0;
    pc         = '0;
    perf_evt   = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // reset state and identity
    check_equal("mie_o", 32'(mie), 32'h0);
    check_equal("mepc_o", mepc, 32'h0);
    read_csr(ADDR_PCMR, rd);
    check_equal("pcmr", rd, 32'h3);
    read_csr(ADDR_MHARTID, rd);
    check_equal("mhartid", rd, (32'(cluster_id) << 5) | 32'(core_id));

    ////////////////////
    // write, set, clear
    ////////////////////
    model_mepc = '0;
    model_ds0  = '0;
    for (int k = 0; k < 6; k++) begin
      op   = csr_op_e'(1 + (k % 3));
      data = $random(seed);
      access_csr(ADDR_MEPC, op, data);
      model_mepc = merge_op(op, model_mepc, data);
      read_csr(ADDR_MEPC, rd);
      check_equal("mepc", rd, model_mepc);
      data = $random(seed);
      access_csr(ADDR_DSCRATCH0, op, data);
      model_ds0 = merge_op(op, model_ds0, data);
      read_csr(ADDR_DSCRATCH0, rd);
      check_equal("dscratch0", rd, model_ds0);
    end
    data = $random(seed);
    access_csr(ADDR_DCSR, CSR_OP_WRITE, data);
    read_csr(ADDR_DCSR, rd);
    check_equal("dcsr", rd, {4'h4, data[27:2], 2'b11});  // debug version, machine prv

    ////////////////////
    // trap entry and return
    ////////////////////
    access_csr(ADDR_MSTATUS, CSR_OP_SET, 32'h1 << MSTATUS_MIE_BIT);
    check_equal("mie_o", 32'(mie), 32'h1);
    pc.pc_if = $random(seed);
    pc.pc_id = $random(seed);
    pc_a     = pc.pc_if;
    trap_pulse(1'b1, 6'h2B, 1'b1, 32'h0000_1234);  // mepc write loses to the trap
    check_equal("mepc_o", mepc, pc_a);
    check_equal("depc_o", depc, pc_a);
    check_equal("mie_o", 32'(mie), 32'h0);
    read_csr(ADDR_MCAUSE, rd);
    check_equal("mcause", rd, 32'h8000_000B);  // interrupt flag lands in bit 31
    ret_pulse(1'b0);
    check_equal("mie_o", 32'(mie), 32'h1);
    trap_pulse(1'b0, 6'h05, 1'b0, '0);
    check_equal("mepc_o", mepc, pc.pc_id);
    ret_pulse(1'b1);
    check_equal("mie_o", 32'(mie), 32'h1);

    ////////////////////
    // event counting
    ////////////////////
    data = $random(seed);
    access_csr(ADDR_PCCR_ALL, CSR_OP_WRITE, data | 32'h1);  // nonzero in every counter
    access_csr(ADDR_PCER, CSR_OP_WRITE, 32'h20);
    access_csr(ADDR_PCCR_ALL, CSR_OP_WRITE, 32'h0);
    n_loads = 3 + ({$random(seed)} % 10);
    perf_evt.mem_store = 1'b1;  // store event active but not enabled
    drive_loads(n_loads);
    perf_evt.mem_store = 1'b0;
    wait_cycles(1);
    read_csr(ADDR_PCCR_BASE + 12'd5, rd);
    check_equal("pccr5", rd, 32'(n_loads));
    read_csr(ADDR_PCCR_BASE + 12'd6, rd);
    check_equal("pccr6", rd, 32'h0);
    access_csr(ADDR_PCMR, CSR_OP_WRITE, 32'h2);  // global enable off
    drive_loads(5);
    wait_cycles(1);
    read_csr(ADDR_PCCR_BASE + 12'd5, rd);
    check_equal("pccr5", rd, 32'(n_loads));
    access_csr(ADDR_PCMR, CSR_OP_WRITE, 32'h3);

    // cycle counter near the top
    access_csr(ADDR_PCER, CSR_OP_WRITE, 32'h1);
    access_csr(ADDR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFFD);
    wait_cycles(5);
    read_csr(ADDR_PCCR_BASE, rd);
    check_equal("pccr0", rd, 32'hFFFF_FFFF);
    wait_cycles(4);
    read_csr(ADDR_PCCR_BASE, rd);
    check_equal("pccr0", rd, 32'hFFFF_FFFF);
    access_csr(ADDR_PCMR, CSR_OP_WRITE, 32'h1);  // saturation off
    wait_cycles(4);
    read_csr(ADDR_PCCR_BASE, rd);
    checks++;
    assert (rd < 32'h20)
      else begin
        errors++;
        $display("ERR pccr0 exp<%h got=%h", 32'h20, rd);
      end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(MAX_CYCLES * PERIOD);
    $display("timeout, sequence still running after %0d clock periods", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+tb
common/csr_pkg.sv
perf/perf_event_map.sv
perf/perf_counter_bank.sv
trap/csr_trap_regs.sv
verilog/csr_access_ctrl.sv
verilog/csr_file_top.sv
tb/csr_file_tb.sv
